//--- mipsPkg.sv
package mipsPkg;

    // table sizes
    localparam int numRegs   = 32;
    localparam int dmemWords = 128;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [$clog2(dmemWords)-1:0] dmemAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;

    // pc step per instruction
    localparam word_t wordBytes = 32'd4;

    // jal writes the return address here
    localparam regAddr_t linkReg = 5'd31;

    // primary opcodes
    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opJ     = 6'h02;
    localparam opcode_t opJal   = 6'h03;
    localparam opcode_t opBeq   = 6'h04;
    localparam opcode_t opBne   = 6'h05;
    localparam opcode_t opAddi  = 6'h08;
    localparam opcode_t opLw    = 6'h23;
    localparam opcode_t opSw    = 6'h2b;

    // R-type function codes
    localparam funct_t fnSll = 6'h00;
    localparam funct_t fnSrl = 6'h02;
    localparam funct_t fnJr  = 6'h08;
    localparam funct_t fnAdd = 6'h20;
    localparam funct_t fnSub = 6'h22;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr  = 6'h25;
    localparam funct_t fnSlt = 6'h2a;

    typedef enum logic [2:0] {
        aluAnd = 3'd0,
        aluOr  = 3'd1,
        aluAdd = 3'd2,
        aluSub = 3'd3,
        aluSlt = 3'd4,
        aluSll = 3'd5,
        aluSrl = 3'd6
    } aluOp_t;

    // decoded control, all zero means no side effects
    typedef struct packed {
        logic   aluSrc;
        logic   memToReg;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        logic   branchNe;
        logic   jump;
        logic   link;
        logic   jumpReg;
        aluOp_t aluOp;
    } ctrl_t;

endpackage

//--- instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  mipsPkg::word_t    instr,
    output mipsPkg::ctrl_t    ctrl,
    output mipsPkg::regAddr_t rsAddr,
    output mipsPkg::regAddr_t rtAddr,
    output mipsPkg::regAddr_t wrAddr,
    output mipsPkg::word_t    imm,
    output mipsPkg::shamt_t   shamt,
    output logic [25:0]       target
);

    mipsPkg::opcode_t  opcode;
    mipsPkg::funct_t   funct;
    mipsPkg::regAddr_t rdAddr;

    // instruction fields
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rdAddr = instr[15:11];
    assign shamt  = instr[10:6];
    assign target = instr[25:0];

    // sign extension of the 16-bit immediate
    assign imm = {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        ctrl = '0;
        case (opcode)
            mipsPkg::opRType: begin
                case (funct)
                    mipsPkg::fnAdd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluAdd;
                    end
                    mipsPkg::fnSub: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSub;
                    end
                    mipsPkg::fnAnd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluAnd;
                    end
                    mipsPkg::fnOr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluOr;
                    end
                    mipsPkg::fnSlt: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSlt;
                    end
                    mipsPkg::fnSll: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSll;
                    end
                    mipsPkg::fnSrl: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSrl;
                    end
                    mipsPkg::fnJr: begin
                        ctrl.jumpReg = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            mipsPkg::opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::aluAdd;
            end
            mipsPkg::opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluOp    = mipsPkg::aluAdd;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::aluAdd;
            end
            // compare by subtraction, pc unit looks at zero
            mipsPkg::opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsPkg::aluSub;
            end
            mipsPkg::opBne: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = mipsPkg::aluSub;
            end
            mipsPkg::opJ: begin
                ctrl.jump = 1'b1;
            end
            mipsPkg::opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // destination register
    always_comb begin
        if (opcode == mipsPkg::opJal) begin
            wrAddr = mipsPkg::linkReg;
        end else if (opcode == mipsPkg::opRType) begin
            wrAddr = rdAddr;
        end else begin
            wrAddr = rtAddr;
        end
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic              clk,
    input  logic              rst_n,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    input  mipsPkg::regAddr_t wrAddr,
    input  logic              wrEn,
    input  mipsPkg::word_t    wrData,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData
);

    mipsPkg::word_t regs [mipsPkg::numRegs];
    logic           wrHit;

    // r0 is never written, so it stays at its reset value
    assign wrHit = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mipsPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrHit) begin
            regs[wrAddr] <= wrData;
        end
    end

    // no bypass, a write shows up on the next cycle
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu (
    input  mipsPkg::aluOp_t op,
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    input  mipsPkg::shamt_t shamt,
    output mipsPkg::word_t  result,
    output logic            zero
);

    always_comb begin
        case (op)
            mipsPkg::aluAnd: begin
                result = a & b;
            end
            mipsPkg::aluOr: begin
                result = a | b;
            end
            mipsPkg::aluAdd: begin
                result = a + b;
            end
            mipsPkg::aluSub: begin
                result = a - b;
            end
            // signed compare
            mipsPkg::aluSlt: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            // shifts act on b, as in the R-type encoding
            mipsPkg::aluSll: begin
                result = b << shamt;
            end
            mipsPkg::aluSrl: begin
                result = b >> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- pcUnit.sv
`timescale 1ns/1ns

module pcUnit (
    input  logic           clk,
    input  logic           rst_n,
    input  mipsPkg::ctrl_t ctrl,
    input  logic           zero,
    input  mipsPkg::word_t imm,
    input  logic [25:0]    target,
    input  mipsPkg::word_t rsData,
    output mipsPkg::word_t pc,
    output mipsPkg::word_t pcPlus4
);

    mipsPkg::word_t nextPc;
    mipsPkg::word_t branchAddr;
    mipsPkg::word_t jumpAddr;
    logic           branchTaken;

    assign pcPlus4 = pc + mipsPkg::wordBytes;

    // beq takes on zero, bne on nonzero
    assign branchTaken = ctrl.branch && (zero != ctrl.branchNe);

    assign branchAddr = pcPlus4 + {imm[29:0], 2'b00};
    assign jumpAddr   = {pcPlus4[31:28], target, 2'b00};

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rsData;
        end else if (ctrl.jump) begin
            nextPc = jumpAddr;
        end else if (branchTaken) begin
            nextPc = branchAddr;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

//--- mipsCore.sv
`timescale 1ns/1ns

module mipsCore (
    input  logic               clk,
    input  logic               rst_n,
    input  mipsPkg::word_t     instr,
    input  mipsPkg::word_t     readData,
    output mipsPkg::word_t     instrAddr,
    output logic               cen,
    output logic               wen,
    output logic               oen,
    output mipsPkg::dmemAddr_t dmemAddr,
    output mipsPkg::word_t     writeData
);

    mipsPkg::ctrl_t    ctrl;
    mipsPkg::regAddr_t rsAddr;
    mipsPkg::regAddr_t rtAddr;
    mipsPkg::regAddr_t wrAddr;
    mipsPkg::word_t    imm;
    mipsPkg::shamt_t   shamt;
    logic [25:0]       target;

    mipsPkg::word_t rsData;
    mipsPkg::word_t rtData;
    mipsPkg::word_t aluB;
    mipsPkg::word_t aluResult;
    logic           aluZero;
    mipsPkg::word_t wbData;
    mipsPkg::word_t pc;
    mipsPkg::word_t pcPlus4;

    instrDecoder u_instrDecoder (
        .instr  (instr),
        .ctrl   (ctrl),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wrAddr (wrAddr),
        .imm    (imm),
        .shamt  (shamt),
        .target (target)
    );

    regFile u_regFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wrAddr (wrAddr),
        .wrEn   (ctrl.regWrite),
        .wrData (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    assign aluB = ctrl.aluSrc ? imm : rtData;

    alu u_alu (
        .op     (ctrl.aluOp),
        .a      (rsData),
        .b      (aluB),
        .shamt  (shamt),
        .result (aluResult),
        .zero   (aluZero)
    );

    pcUnit u_pcUnit (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .zero    (aluZero),
        .imm     (imm),
        .target  (target),
        .rsData  (rsData),
        .pc      (pc),
        .pcPlus4 (pcPlus4)
    );

    // write-back, link has priority
    always_comb begin
        if (ctrl.link) begin
            wbData = pcPlus4;
        end else if (ctrl.memToReg) begin
            wbData = readData;
        end else begin
            wbData = aluResult;
        end
    end

    assign instrAddr = pc;

    // data memory strobes, all active low
    assign cen = ~(ctrl.memRead | ctrl.memWrite);
    assign wen = ~ctrl.memWrite;
    assign oen = ~ctrl.memRead;

    // word address from the byte address
    assign dmemAddr  = aluResult[8:2];
    assign writeData = rtData;

endmodule

//--- mipsCore_checker.sv
`timescale 1ns/1ns

module mipsCore_checker (
    input logic           clk,
    input logic           rst_n,
    input mipsPkg::word_t instrAddr,
    input logic           cen,
    input logic           wen,
    input logic           oen
);

    // a write also selects the memory
    writeSelects: assert property (@(posedge clk) disable iff (!rst_n) !wen |-> !cen)
        else $error("wen low while cen is high");

    noReadWrite: assert property (@(posedge clk) disable iff (!rst_n) !(!wen && !oen))
        else $error("wen and oen low together");

    fetchAligned: assert property (@(posedge clk) disable iff (!rst_n) instrAddr[1:0] == 2'b00)
        else $error("instrAddr not word aligned");

    // first fetch after reset
    resetFetch: assert property (@(posedge clk) $rose(rst_n) |-> instrAddr == '0)
        else $error("first fetch after reset not at address zero");

endmodule

bind mipsCore mipsCore_checker u_mipsCore_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .instrAddr (instrAddr),
    .cen       (cen),
    .wen       (wen),
    .oen       (oen)
);

//--- mipsCore_tb.sv
`timescale 1ns/1ns

module mipsCore_tb;

    localparam int numTests  = 15;
    localparam int progWords = 16;
    localparam int waitLimit = 64;

    logic               clk;
    logic               rst_n;
    mipsPkg::word_t     instr;
    mipsPkg::word_t     readData;
    mipsPkg::word_t     instrAddr;
    logic               cen;
    logic               wen;
    logic               oen;
    mipsPkg::dmemAddr_t dmemAddr;
    mipsPkg::word_t     writeData;

    mipsPkg::word_t     rom [progWords];
    mipsPkg::word_t     dmem [mipsPkg::dmemWords];
    string              testName [numTests];
    mipsPkg::word_t     prog [numTests][progWords];
    mipsPkg::dmemAddr_t expAddr [numTests];
    mipsPkg::word_t     expData [numTests];
    int                 skipStores [numTests];
    mipsPkg::word_t     lcgState;
    int                 errors;
    int                 passCount;
    int                 failCount;

    mipsCore u_mipsCore (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .readData  (readData),
        .instrAddr (instrAddr),
        .cen       (cen),
        .wen       (wen),
        .oen       (oen),
        .dmemAddr  (dmemAddr),
        .writeData (writeData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fetch and load answer within the cycle, nop past the program
    assign instr    = (instrAddr[31:6] == '0) ? rom[instrAddr[5:2]] : '0;
    // load data only while the memory is selected for a read
    assign readData = (!cen && !oen) ? dmem[dmemAddr] : 'x;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mipsPkg::dmemWords; i++) begin
                dmem[i] <= 32'ha5a50000 | mipsPkg::word_t'(i);
            end
        end else if (!cen && !wen) begin
            dmem[dmemAddr] <= writeData;
        end
    end

    function automatic mipsPkg::word_t rType(mipsPkg::regAddr_t rs, mipsPkg::regAddr_t rt,
            mipsPkg::regAddr_t rd, mipsPkg::shamt_t sh, mipsPkg::funct_t fn);
        return {mipsPkg::opRType, rs, rt, rd, sh, fn};
    endfunction

    function automatic mipsPkg::word_t iType(mipsPkg::opcode_t op, mipsPkg::regAddr_t rs,
            mipsPkg::regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::word_t signExt(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [15:0] randImm();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    // expected ALU results, in the order of the first table rows
    function automatic mipsPkg::word_t refAlu(int k, mipsPkg::word_t a, mipsPkg::word_t b,
            mipsPkg::shamt_t sh);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            5: return b << sh;
            6: return b >> sh;
            default: return '0;
        endcase
    endfunction

    task automatic buildTable();
        string           names [7] = '{"add", "sub", "and", "or", "slt", "sll", "srl"};
        mipsPkg::funct_t fns [7] = '{mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd,
            mipsPkg::fnOr, mipsPkg::fnSlt, mipsPkg::fnSll, mipsPkg::fnSrl};
        logic [15:0]     immA;
        logic [15:0]     immB;
        logic [15:0]     shBits;
        logic            same;
        logic            taken;
        string           opName;
        string           outcome;
        lcgState = 32'd61;
        foreach (prog[r, n]) prog[r][n] = '0;
        foreach (skipStores[r]) skipStores[r] = 0;
        for (int k = 0; k < 7; k++) begin
            immA   = randImm();
            immB   = randImm();
            shBits = randImm();
            testName[k] = names[k];
            prog[k][0]  = iType(mipsPkg::opAddi, 5'd0, 5'd1, immA);
            prog[k][1]  = iType(mipsPkg::opAddi, 5'd0, 5'd2, immB);
            prog[k][2]  = (k >= 5) ? rType(5'd0, 5'd2, 5'd3, shBits[4:0], fns[k])
                                   : rType(5'd1, 5'd2, 5'd3, 5'd0, fns[k]);
            prog[k][3]  = iType(mipsPkg::opSw, 5'd0, 5'd3, 16'((8 + k) * 4));
            expAddr[k]  = mipsPkg::dmemAddr_t'(8 + k);
            expData[k]  = refAlu(k, signExt(immA), signExt(immB), shBits[4:0]);
        end
        // store, load back into r2, store r2 elsewhere
        immA = randImm();
        testName[7]   = "loadStore";
        prog[7][0]    = iType(mipsPkg::opAddi, 5'd0, 5'd1, immA);
        prog[7][1]    = iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd40);
        prog[7][2]    = iType(mipsPkg::opLw, 5'd0, 5'd2, 16'd40);
        prog[7][3]    = iType(mipsPkg::opSw, 5'd0, 5'd2, 16'd80);
        expAddr[7]    = 7'd20;
        expData[7]    = signExt(immA);
        skipStores[7] = 1;
        // beq eq, beq ne, bne ne, bne eq
        for (int k = 0; k < 4; k++) begin
            same  = (k == 0) || (k == 3);
            taken = (k >= 2) ? !same : same;
            opName = (k >= 2) ? "bne" : "beq";
            if (taken) begin
                outcome = "Taken";
            end else begin
                outcome = "NotTaken";
            end
            testName[8 + k] = {opName, outcome};
            prog[8 + k][0]  = iType(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5);
            prog[8 + k][1]  = iType(mipsPkg::opAddi, 5'd0, 5'd2, same ? 16'd5 : 16'd7);
            prog[8 + k][2]  = iType((k >= 2) ? mipsPkg::opBne : mipsPkg::opBeq,
                                    5'd1, 5'd2, 16'd2);
            prog[8 + k][3]  = iType(mipsPkg::opAddi, 5'd0, 5'd3, 16'h1111);
            prog[8 + k][4]  = iType(mipsPkg::opSw, 5'd0, 5'd3, 16'd16);
            prog[8 + k][5]  = iType(mipsPkg::opAddi, 5'd0, 5'd3, 16'h2222);
            prog[8 + k][6]  = iType(mipsPkg::opSw, 5'd0, 5'd3, 16'd16);
            expAddr[8 + k]  = 7'd4;
            expData[8 + k]  = taken ? 32'h2222 : 32'h1111;
        end
        // jal at word 1 into a routine at word 5, jr back, j over the poison store
        for (int k = 12; k < 14; k++) begin
            prog[k][0] = iType(mipsPkg::opAddi, 5'd0, 5'd1, 16'h0033);
            prog[k][1] = {mipsPkg::opJal, 26'd5};
            prog[k][2] = {mipsPkg::opJ, 26'd4};
            prog[k][3] = iType(mipsPkg::opSw, 5'd0, 5'd0, 16'd36);
            prog[k][4] = iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd32);
            prog[k][5] = iType(mipsPkg::opSw, 5'd0, 5'd31, 16'd12);
            prog[k][6] = rType(5'd31, 5'd0, 5'd0, 5'd0, mipsPkg::fnJr);
        end
        testName[12]   = "jalLink";
        expAddr[12]    = 7'd3;
        expData[12]    = 32'd4 + mipsPkg::wordBytes;
        testName[13]   = "jrJump";
        expAddr[13]    = 7'd8;
        expData[13]    = 32'h33;
        skipStores[13] = 1;
        testName[14]   = "regZero";
        prog[14][0]    = iType(mipsPkg::opAddi, 5'd0, 5'd0, 16'h0055);
        prog[14][1]    = iType(mipsPkg::opSw, 5'd0, 5'd0, 16'd44);
        expAddr[14]    = 7'd11;
        expData[14]    = '0;
    endtask

    task automatic checkWord(string name, mipsPkg::word_t expected, mipsPkg::word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkAddr(string name, mipsPkg::dmemAddr_t expected,
            mipsPkg::dmemAddr_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic runTest(int t);
        int   cycles;
        int   stores;
        logic found;
        int   errBefore;
        errBefore = errors;
        cycles    = 0;
        stores    = 0;
        found     = 1'b0;
        @(posedge clk);
        rst_n <= 1'b0;
        for (int n = 0; n < progWords; n++) begin
            rom[n] = prog[t][n];
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checkWord({testName[t], " resetPc"}, '0, instrAddr);
        // every program opens with addi, so no strobe is active yet
        checkBit({testName[t], " resetCen"}, 1'b1, cen);
        checkBit({testName[t], " resetWen"}, 1'b1, wen);
        checkBit({testName[t], " resetOen"}, 1'b1, oen);
        // count store cycles until the one under test
        while (!found && cycles < waitLimit) begin
            if (!wen && stores == skipStores[t]) begin
                found = 1'b1;
            end else begin
                if (!wen) begin
                    stores++;
                end
                @(negedge clk);
                cycles++;
            end
        end
        if (found) begin
            checkBit({testName[t], " cen"}, 1'b0, cen);
            checkBit({testName[t], " oen"}, 1'b1, oen);
            checkAddr({testName[t], " addr"}, expAddr[t], dmemAddr);
            checkWord({testName[t], " data"}, expData[t], writeData);
        end else begin
            $display("%s: the expected store never came within %0d cycles", testName[t],
                     waitLimit);
            errors++;
        end
        if (errors == errBefore) begin
            passCount++;
            $display("PASS %s", testName[t]);
        end else begin
            failCount++;
            $display("FAIL %s", testName[t]);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        errors    = 0;
        passCount = 0;
        failCount = 0;
        buildTable();
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("%0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- mipsCore.f
mipsPkg.sv
instrDecoder.sv
regFile.sv
alu.sv
pcUnit.sv
mipsCore.sv
mipsCore_checker.sv
mipsCore_tb.sv

//--- Makefile
TOP := mipsCore_tb

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f mipsCore.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

lint:
	verilator --lint-only -Wall --top-module mipsCore mipsPkg.sv instrDecoder.sv \
		regFile.sv alu.sv pcUnit.sv mipsCore.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
